// ==== Makefile ====
# Verilator build and run for the USB4 lane pair encoder

VERILATOR ?= verilator
TOP       ?= lane_encoder_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR PASS_MSG VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "^$(PASS_MSG)$$"; then \
		echo "test: simulation passed"; \
	else \
		echo "test: simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+source
source/usb4_link_pkg.sv
source/enc_ctrl_pkg.sv
source/symbol_decode.sv
source/block_assembler.sv
source/block_emitter.sv
source/lane_encoder_top.sv
testbench/lane_encoder_asserts.sv
testbench/lane_encoder_tb.sv

// ==== source/block_assembler.sv ====
/* Block assembler
   Collects byte pairs into per-lane payload buffers until a block is full */

`timescale 1ns/1ps
`default_nettype none

`include "enc_params.svh"

module block_assembler
	import usb4_link_pkg::*;
(
	input  wire                   enc_clk,
	input  wire                   rst,
	input  wire                   enable,
	input  wire gen_speed_e       gen_speed,
	input  wire                   pair_valid,
	input  wire [`ENC_BYTE_W-1:0] pair_lane_0,
	input  wire [`ENC_BYTE_W-1:0] pair_lane_1,
	input  wire sym_kind_e        pair_kind,
	output logic                  pair_ready,
	output logic                  blk_valid,
	output logic [`ENC_G3_BYTES*`ENC_BYTE_W-1:0] blk_lane_0,
	output logic [`ENC_G3_BYTES*`ENC_BYTE_W-1:0] blk_lane_1,
	output sym_kind_e             blk_kind,
	output logic [4:0]            blk_len,
	input  wire                   blk_ready
);

	logic [4:0] byte_cnt;    // Bytes already in the buffer
	logic [4:0] target_len;
	logic [6:0] bit_base;    // First payload bit of the current byte
	logic       pair_xfer;
	logic       blk_xfer;
	logic       last_pair;

	// ----------------------------------------------------------------------
	// Block length from the encoding scheme
	// ----------------------------------------------------------------------
	function automatic logic [4:0] block_bytes(input gen_speed_e spd);
		case (spd)
			GEN_2:   return 5'(`ENC_G2_BYTES);
			GEN_3:   return 5'(`ENC_G3_BYTES);
			default: return 5'd1; // Raw, one byte per symbol
		endcase
	endfunction

	assign target_len = block_bytes(gen_speed);
	assign bit_base   = {byte_cnt[3:0], 3'b000};

	// One buffer only, it frees up when the emitter takes the block
	assign pair_ready = !blk_valid;
	assign pair_xfer  = pair_valid && pair_ready;
	assign blk_xfer   = blk_valid && blk_ready;
	assign last_pair  = (byte_cnt + 5'd1 == target_len);

	// ----------------------------------------------------------------------
	// Byte counter and block state
	// ----------------------------------------------------------------------
	always_ff @(posedge enc_clk or negedge rst) begin
		if (!rst) begin
			byte_cnt  <= '0;
			blk_valid <= 1'b0;
		end else if (!enable) begin
			byte_cnt  <= '0; // Partial block is dropped
			blk_valid <= 1'b0;
		end else begin
			if (pair_xfer) begin
				if (last_pair) begin
					byte_cnt  <= '0;
					blk_valid <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 5'd1;
				end
			end else if (blk_xfer) begin
				blk_valid <= 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Payload buffers
	// ----------------------------------------------------------------------
	always_ff @(posedge enc_clk) begin
		if (pair_xfer) begin
			blk_lane_0[bit_base +: `ENC_BYTE_W] <= pair_lane_0;
			blk_lane_1[bit_base +: `ENC_BYTE_W] <= pair_lane_1;
			if (byte_cnt == 5'd0) begin
				blk_kind <= pair_kind; // First pair decides the header
			end
			if (last_pair) begin
				blk_len <= target_len;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/block_emitter.sv ====
/* Block emitter
   Adds the sync header to each lane and drives the serializer handshake */

`timescale 1ns/1ps
`default_nettype none

`include "enc_params.svh"

module block_emitter
	import enc_ctrl_pkg::*, usb4_link_pkg::*;
(
	input  wire                 enc_clk,
	input  wire                 rst,
	input  wire                 enable,
	input  wire gen_speed_e     gen_speed,
	input  wire                 blk_valid,
	input  wire [`ENC_G3_BYTES*`ENC_BYTE_W-1:0] blk_lane_0,
	input  wire [`ENC_G3_BYTES*`ENC_BYTE_W-1:0] blk_lane_1,
	input  wire sym_kind_e      blk_kind,
	input  wire [4:0]           blk_len,
	output logic                blk_ready,
	output logic                sym_req,
	output logic [`ENC_SYM_W-1:0] lane_0_sym,
	output logic [`ENC_SYM_W-1:0] lane_1_sym,
	input  wire                 sym_ack
);

	localparam int BUF_W   = `ENC_G3_BYTES * `ENC_BYTE_W;
	localparam int G2_BITS = `ENC_G2_BYTES * `ENC_BYTE_W;

	hs_tx_state_e         state;
	logic [`ENC_SYM_W-1:0] frame_0;
	logic [`ENC_SYM_W-1:0] frame_1;
	logic                 blk_xfer;

	// ----------------------------------------------------------------------
	// Framing
	// ----------------------------------------------------------------------
	// Bytes at or above blk_len are zeroed
	function automatic logic [BUF_W-1:0] mask_payload(input logic [BUF_W-1:0] data,
		input logic [4:0] len);
		logic [BUF_W-1:0] res;
		res = '0;
		for (int k = 0; k < `ENC_G3_BYTES; k++) begin
			if (5'(k) < len) begin
				res[k*`ENC_BYTE_W +: `ENC_BYTE_W] = data[k*`ENC_BYTE_W +: `ENC_BYTE_W];
			end
		end
		return res;
	endfunction

	function automatic logic [`ENC_SYM_W-1:0] frame_lane(input logic [BUF_W-1:0] payload,
		input gen_speed_e spd, input sym_kind_e kind);
		logic [`ENC_SYM_W-1:0] sym;
		sym = '0;
		case (spd)
			GEN_2: sym[G2_BITS+1:0] = {(kind == KIND_OS) ? 2'b01 : 2'b10,
				payload[G2_BITS-1:0]};
			GEN_3: sym = {(kind == KIND_OS) ? 4'b0101 : 4'b1010, payload};
			default: sym[`ENC_BYTE_W-1:0] = payload[`ENC_BYTE_W-1:0]; // Raw byte
		endcase
		return sym;
	endfunction

	always_comb begin
		frame_0 = frame_lane(mask_payload(blk_lane_0, blk_len), gen_speed, blk_kind);
		frame_1 = frame_lane(mask_payload(blk_lane_1, blk_len), gen_speed, blk_kind);
	end

	// ----------------------------------------------------------------------
	// Output handshake
	// ----------------------------------------------------------------------
	assign blk_ready = (state == TX_EMPTY);
	assign sym_req   = (state == TX_REQ);
	assign blk_xfer  = blk_valid && blk_ready;

	always_ff @(posedge enc_clk or negedge rst) begin
		if (!rst) begin
			state <= TX_EMPTY;
		end else if (!enable) begin
			state <= TX_EMPTY;
		end else begin
			case (state)
				TX_EMPTY:    if (blk_valid) state <= TX_REQ;
				TX_REQ:      if (sym_ack) state <= TX_WAIT_REL;
				TX_WAIT_REL: if (!sym_ack) state <= TX_EMPTY; // Cycle complete
				default:     state <= TX_EMPTY;
			endcase
		end
	end

	// Symbols stay put until the next block is taken
	always_ff @(posedge enc_clk) begin
		if (blk_xfer) begin
			lane_0_sym <= frame_0;
			lane_1_sym <= frame_1;
		end
	end

endmodule

`default_nettype wire

// ==== source/enc_ctrl_pkg.sv ====
/* Encoder control types
   States of the input and output four-phase handshake machines */

`default_nettype none

package enc_ctrl_pkg;

	// Input side, answers the transport source
	typedef enum logic [1:0] {
		RX_IDLE     = 2'd0, // Waiting for byte_req
		RX_HOLD     = 2'd1, // Pair captured, offered to assembler
		RX_WAIT_REL = 2'd2  // byte_ack high until byte_req drops
	} hs_rx_state_e;

	// Output side, drives the serializer
	typedef enum logic [1:0] {
		TX_EMPTY    = 2'd0, // Ready for a block
		TX_REQ      = 2'd1, // sym_req high, waiting for sym_ack
		TX_WAIT_REL = 2'd2  // Waiting for sym_ack to drop
	} hs_tx_state_e;

	// Both machines are small, the fourth code is never reached
	// and decodes back to the idle state in each machine

endpackage

`default_nettype wire

// ==== source/enc_params.svh ====
/* Encoder parameters
   Lane widths and block sizes fixed by the USB4 logical layer */

`ifndef ENC_PARAMS_SVH
`define ENC_PARAMS_SVH

// ----------------------------------------------------------------------
// Lane widths
// ----------------------------------------------------------------------
`define ENC_BYTE_W    8   // One lane byte
`define ENC_SYM_W     132 // Widest symbol, 128b/132b

// ----------------------------------------------------------------------
// Block sizes and selector codes
// ----------------------------------------------------------------------
`define ENC_G2_BYTES  8   // 64b/66b payload bytes
`define ENC_G3_BYTES  16  // 128b/132b payload bytes
`define ENC_OS_SEL    8   // d_sel value of an ordered set

`endif

// ==== source/lane_encoder_top.sv ====
/* Lane pair transmit encoder
   Decoder, block assembler and emitter between transport and serializer */

`timescale 1ns/1ps
`default_nettype none

`include "enc_params.svh"

module lane_encoder_top
	import usb4_link_pkg::*;
(
	input  wire                   enc_clk,
	input  wire                   rst,
	input  wire                   enable,
	input  wire gen_speed_e       gen_speed,
	input  wire                   byte_req,
	input  wire [`ENC_BYTE_W-1:0] lane_0_tx,
	input  wire [`ENC_BYTE_W-1:0] lane_1_tx,
	input  wire [3:0]             d_sel,
	output logic                  byte_ack,
	output logic                  sym_req,
	output logic [`ENC_SYM_W-1:0] lane_0_sym,
	output logic [`ENC_SYM_W-1:0] lane_1_sym,
	input  wire                   sym_ack
);

	// ----------------------------------------------------------------------
	// Decoder to assembler
	// ----------------------------------------------------------------------
	logic                   pair_valid;
	logic                   pair_ready;
	logic [`ENC_BYTE_W-1:0] pair_lane_0;
	logic [`ENC_BYTE_W-1:0] pair_lane_1;
	sym_kind_e              pair_kind;

	// ----------------------------------------------------------------------
	// Assembler to emitter
	// ----------------------------------------------------------------------
	logic                                  blk_valid;
	logic                                  blk_ready;
	logic [`ENC_G3_BYTES*`ENC_BYTE_W-1:0] blk_lane_0;
	logic [`ENC_G3_BYTES*`ENC_BYTE_W-1:0] blk_lane_1;
	sym_kind_e                             blk_kind;
	logic [4:0]                            blk_len;

	symbol_decode u_decode (
		.enc_clk     (enc_clk),
		.rst         (rst),
		.enable      (enable),
		.byte_req    (byte_req),
		.lane_0_tx   (lane_0_tx),
		.lane_1_tx   (lane_1_tx),
		.d_sel       (d_sel),
		.byte_ack    (byte_ack),
		.pair_valid  (pair_valid),
		.pair_lane_0 (pair_lane_0),
		.pair_lane_1 (pair_lane_1),
		.pair_kind   (pair_kind),
		.pair_ready  (pair_ready)
	);

	block_assembler u_assemble (
		.enc_clk     (enc_clk),
		.rst         (rst),
		.enable      (enable),
		.gen_speed   (gen_speed),
		.pair_valid  (pair_valid),
		.pair_lane_0 (pair_lane_0),
		.pair_lane_1 (pair_lane_1),
		.pair_kind   (pair_kind),
		.pair_ready  (pair_ready),
		.blk_valid   (blk_valid),
		.blk_lane_0  (blk_lane_0),
		.blk_lane_1  (blk_lane_1),
		.blk_kind    (blk_kind),
		.blk_len     (blk_len),
		.blk_ready   (blk_ready)
	);

	block_emitter u_emit (
		.enc_clk    (enc_clk),
		.rst        (rst),
		.enable     (enable),
		.gen_speed  (gen_speed),
		.blk_valid  (blk_valid),
		.blk_lane_0 (blk_lane_0),
		.blk_lane_1 (blk_lane_1),
		.blk_kind   (blk_kind),
		.blk_len    (blk_len),
		.blk_ready  (blk_ready),
		.sym_req    (sym_req),
		.lane_0_sym (lane_0_sym),
		.lane_1_sym (lane_1_sym),
		.sym_ack    (sym_ack)
	);

endmodule

`default_nettype wire

// ==== source/symbol_decode.sv ====
/* Input symbol decoder
   Four-phase receiver that captures a lane byte pair and classifies it */

`timescale 1ns/1ps
`default_nettype none

`include "enc_params.svh"

module symbol_decode
	import enc_ctrl_pkg::*, usb4_link_pkg::*;
(
	input  wire                   enc_clk,
	input  wire                   rst,
	input  wire                   enable,
	input  wire                   byte_req,
	input  wire [`ENC_BYTE_W-1:0] lane_0_tx,
	input  wire [`ENC_BYTE_W-1:0] lane_1_tx,
	input  wire [3:0]             d_sel,
	output logic                  byte_ack,
	output logic                  pair_valid,
	output logic [`ENC_BYTE_W-1:0] pair_lane_0,
	output logic [`ENC_BYTE_W-1:0] pair_lane_1,
	output sym_kind_e             pair_kind,
	input  wire                   pair_ready
);

	hs_rx_state_e state;
	logic         capture;

	assign capture    = enable && (state == RX_IDLE) && byte_req; // Source data is stable here
	assign pair_valid = (state == RX_HOLD);
	assign byte_ack   = (state == RX_WAIT_REL);

	// ----------------------------------------------------------------------
	// Handshake machine
	// ----------------------------------------------------------------------
	always_ff @(posedge enc_clk or negedge rst) begin
		if (!rst) begin
			state <= RX_IDLE;
		end else if (!enable) begin
			state <= RX_IDLE;
		end else begin
			case (state)
				RX_IDLE:     if (byte_req) state <= RX_HOLD;
				RX_HOLD:     if (pair_ready) state <= RX_WAIT_REL; // Ack once assembler took it
				RX_WAIT_REL: if (!byte_req) state <= RX_IDLE;
				default:     state <= RX_IDLE;
			endcase
		end
	end

	// Pair and its kind, held while pair_valid is high
	always_ff @(posedge enc_clk) begin
		if (capture) begin
			pair_lane_0 <= lane_0_tx;
			pair_lane_1 <= lane_1_tx;
			pair_kind   <= (d_sel == 4'(`ENC_OS_SEL)) ? KIND_OS : KIND_DATA;
		end
	end

endmodule

`default_nettype wire

// ==== source/usb4_link_pkg.sv ====
/* USB4 link types
   Generation speeds and the kind of symbol carried in a block */

`default_nettype none

package usb4_link_pkg;

	// ----------------------------------------------------------------------
	// Encoding scheme selected by gen_speed
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		GEN_RAW = 2'd0, // Bytes passed on alone
		GEN_3   = 2'd1, // 128b/132b
		GEN_2   = 2'd2  // 64b/66b
	} gen_speed_e;

	// ----------------------------------------------------------------------
	// Payload kind, picks the sync header
	// ----------------------------------------------------------------------
	typedef enum logic {
		KIND_DATA = 1'b0,
		KIND_OS   = 1'b1  // Ordered set
	} sym_kind_e;

endpackage

`default_nettype wire

// ==== testbench/lane_encoder_asserts.sv ====
/* Encoder handshake assertions
   Watches both four-phase ports of the lane pair encoder */

`timescale 1ns/1ps
`default_nettype none

`include "enc_params.svh"

module lane_encoder_asserts (
	input wire                  enc_clk,
	input wire                  rst,
	input wire                  byte_req,
	input wire                  byte_ack,
	input wire                  sym_req,
	input wire                  sym_ack,
	input wire [`ENC_SYM_W-1:0] lane_0_sym,
	input wire [`ENC_SYM_W-1:0] lane_1_sym
);

	// ----------------------------------------------------------------------
	// Reset
	// ----------------------------------------------------------------------
	reset_idle: assert property (@(posedge enc_clk) !rst |-> (!byte_ack && !sym_req))
		else $error("byte_ack or sym_req high while in reset");

	// ----------------------------------------------------------------------
	// Four-phase ordering
	// ----------------------------------------------------------------------
	ack_needs_req: assert property (@(posedge enc_clk) disable iff (!rst)
		$rose(byte_ack) |-> $past(byte_req))
		else $error("byte_ack rose while byte_req was low");

	req_waits_ack: assert property (@(posedge enc_clk) disable iff (!rst)
		$fell(sym_req) |-> $past(sym_ack))
		else $error("sym_req dropped before sym_ack rose");

	// Symbols frozen for the whole request phase
	sym_stable: assert property (@(posedge enc_clk) disable iff (!rst)
		(sym_req && $past(sym_req)) |-> ($stable(lane_0_sym) && $stable(lane_1_sym)))
		else $error("lane symbol changed while sym_req was high");

endmodule

bind lane_encoder_top lane_encoder_asserts u_asserts (
	.enc_clk    (enc_clk),
	.rst        (rst),
	.byte_req   (byte_req),
	.byte_ack   (byte_ack),
	.sym_req    (sym_req),
	.sym_ack    (sym_ack),
	.lane_0_sym (lane_0_sym),
	.lane_1_sym (lane_1_sym)
);

`default_nettype wire

// ==== testbench/lane_encoder_tb.sv ====
/* Lane pair encoder testbench
   Table-driven source, reference framing model and serializer responder */

`timescale 1ns/1ps
`default_nettype none

`include "enc_params.svh"

module lane_encoder_tb
	import usb4_link_pkg::*;
();

	localparam int          CLK_PERIOD = 40;
	localparam int          PAYLOAD_W  = `ENC_G3_BYTES * `ENC_BYTE_W;
	localparam logic [31:0] SEED       = 32'd24194;

	logic                   enc_clk;
	logic                   rst;
	logic                   enable;
	gen_speed_e             gen_speed;
	logic                   byte_req;
	logic [`ENC_BYTE_W-1:0] lane_0_tx;
	logic [`ENC_BYTE_W-1:0] lane_1_tx;
	logic [3:0]             d_sel;
	logic                   byte_ack;
	logic                   sym_req;
	logic [`ENC_SYM_W-1:0]  lane_0_sym;
	logic [`ENC_SYM_W-1:0]  lane_1_sym;
	logic                   sym_ack;

	// Stimulus table columns
	string      tbl_name[$];
	gen_speed_e tbl_speed[$];
	logic [3:0] tbl_sel[$];    // d_sel of the first pair in each block
	int         tbl_blocks[$];
	int         tbl_delay[$];  // Max sym_ack delay in cycles
	int         tbl_tail[$];   // Pairs left in a partial block

	logic [`ENC_SYM_W-1:0] exp_lane_0[$];
	logic [`ENC_SYM_W-1:0] exp_lane_1[$];

	logic [31:0] data_rng;
	logic [31:0] delay_rng;
	string       cur_name;
	int          cur_max_delay;
	int          errors      = 0;
	int          checks      = 0;
	int          cycles      = 0;
	int          cycle_limit = 0;

	lane_encoder_top u_dut (
		.enc_clk    (enc_clk),
		.rst        (rst),
		.enable     (enable),
		.gen_speed  (gen_speed),
		.byte_req   (byte_req),
		.lane_0_tx  (lane_0_tx),
		.lane_1_tx  (lane_1_tx),
		.d_sel      (d_sel),
		.byte_ack   (byte_ack),
		.sym_req    (sym_req),
		.lane_0_sym (lane_0_sym),
		.lane_1_sym (lane_1_sym),
		.sym_ack    (sym_ack)
	);

	initial begin
		enc_clk = 1'b0;
		forever #(CLK_PERIOD / 2) enc_clk = ~enc_clk;
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int block_pairs(input gen_speed_e spd);
		case (spd)
			GEN_2:   return `ENC_G2_BYTES;
			GEN_3:   return `ENC_G3_BYTES;
			default: return 1;
		endcase
	endfunction

	// Header sits above the payload and higher bits stay zero
	function automatic logic [`ENC_SYM_W-1:0] frame_expected(input logic [PAYLOAD_W-1:0] pay,
		input gen_speed_e spd, input logic os);
		logic [`ENC_SYM_W-1:0] sym;
		sym = '0;
		if (spd == GEN_2) begin
			sym[63:0]  = pay[63:0];
			sym[65:64] = os ? 2'b01 : 2'b10;
		end else if (spd == GEN_3) begin
			sym[127:0]   = pay;
			sym[131:128] = os ? 4'b0101 : 4'b1010;
		end else begin
			sym[7:0] = pay[7:0]; // Raw byte only
		end
		return sym;
	endfunction

	task automatic add_row(input string name, input gen_speed_e spd, input logic [3:0] sel,
		input int blocks, input int delay, input int tail);
		tbl_name.push_back(name);
		tbl_speed.push_back(spd);
		tbl_sel.push_back(sel);
		tbl_blocks.push_back(blocks);
		tbl_delay.push_back(delay);
		tbl_tail.push_back(tail);
	endtask

	task automatic load_table();
		//      name               speed    sel    blocks delay tail
		add_row("gen2_data",       GEN_2,   4'd0,  4,     3,    0);
		add_row("gen2_os",         GEN_2,   4'd8,  3,     2,    3);
		add_row("gen3_os",         GEN_3,   4'd8,  3,     2,    0);
		add_row("gen3_data",       GEN_3,   4'd1,  3,     4,    7);
		add_row("raw_bytes",       GEN_RAW, 4'd9,  20,    3,    0);
		add_row("gen2_stall",      GEN_2,   4'd2,  6,     40,   0);
		add_row("gen3_os_stall",   GEN_3,   4'd8,  3,     30,   5);
		add_row("gen2_after_drop", GEN_2,   4'd0,  2,     1,    0);
		add_row("raw_stall",       GEN_RAW, 4'd8,  16,    5,    0);
	endtask

	// One input four-phase cycle started on a falling edge
	task automatic send_pair(input logic [7:0] b0, input logic [7:0] b1, input logic [3:0] sel);
		lane_0_tx = b0;
		lane_1_tx = b1;
		d_sel     = sel;
		byte_req  = 1'b1;
		@(negedge enc_clk);
		while (!byte_ack) @(negedge enc_clk);
		byte_req = 1'b0;
		@(negedge enc_clk);
		while (byte_ack) @(negedge enc_clk);
	endtask

	task automatic run_row(input int r);
		int                   pairs;
		logic [PAYLOAD_W-1:0] pay_0;
		logic [PAYLOAD_W-1:0] pay_1;
		logic [7:0]           b0[`ENC_G3_BYTES];
		logic [7:0]           b1[`ENC_G3_BYTES];
		logic [3:0]           sel[`ENC_G3_BYTES];
		logic                 os;
		cur_name      = tbl_name[r];
		cur_max_delay = tbl_delay[r];
		pairs         = block_pairs(tbl_speed[r]);
		enable        = 1'b0;
		gen_speed     = tbl_speed[r]; // Only moved while disabled
		repeat (2) @(negedge enc_clk);
		enable = 1'b1;
		@(negedge enc_clk);
		for (int blk = 0; blk < tbl_blocks[r]; blk++) begin
			pay_0 = '0;
			pay_1 = '0;
			for (int k = 0; k < pairs; k++) begin
				data_rng        = xorshift(data_rng);
				b0[k]           = data_rng[7:0];
				b1[k]           = data_rng[15:8];
				sel[k]          = (k == 0) ? tbl_sel[r] : data_rng[19:16];
				pay_0[8*k +: 8] = b0[k];
				pay_1[8*k +: 8] = b1[k];
			end
			os = (sel[0] == 4'(`ENC_OS_SEL)); // Block kind from its first pair
			exp_lane_0.push_back(frame_expected(pay_0, tbl_speed[r], os));
			exp_lane_1.push_back(frame_expected(pay_1, tbl_speed[r], os));
			for (int k = 0; k < pairs; k++) begin
				send_pair(b0[k], b1[k], sel[k]);
			end
		end
		// Partial block is lost when enable falls
		for (int k = 0; k < tbl_tail[r]; k++) begin
			data_rng = xorshift(data_rng);
			send_pair(data_rng[7:0], data_rng[15:8], data_rng[19:16]);
		end
		while (exp_lane_0.size() != 0 || sym_req || sym_ack) @(negedge enc_clk);
		repeat (4) @(negedge enc_clk);
		checks++;
		assert (exp_lane_0.size() == 0 && !sym_req) else begin
			$display("Case %s ended with symbols missing or an extra request", cur_name);
			errors++;
		end
		enable = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// Serializer responder
	// ----------------------------------------------------------------------
	initial begin : serializer
		int                    delay;
		logic [`ENC_SYM_W-1:0] want_0;
		logic [`ENC_SYM_W-1:0] want_1;
		delay_rng = SEED;
		forever begin
			@(negedge enc_clk);
			if (sym_req && !sym_ack) begin
				delay_rng = xorshift(delay_rng);
				delay     = int'(delay_rng % 32'(cur_max_delay + 1));
				repeat (delay) @(negedge enc_clk);
				checks++;
				assert (exp_lane_0.size() != 0) else begin
					$display("Case %s produced a symbol that was never expected", cur_name);
					errors++;
				end
				if (exp_lane_0.size() != 0) begin
					want_0 = exp_lane_0.pop_front();
					want_1 = exp_lane_1.pop_front();
					checks += 2;
					assert (lane_0_sym === want_0) else begin
						$display("** Error %s lane 0: expected %h, actual %h",
							cur_name, want_0, lane_0_sym);
						errors++;
					end
					assert (lane_1_sym === want_1) else begin
						$display("** Error %s lane 1: expected %h, actual %h",
							cur_name, want_1, lane_1_sym);
						errors++;
					end
				end
				sym_ack = 1'b1;
				@(negedge enc_clk);
				while (sym_req) @(negedge enc_clk);
				sym_ack = 1'b0;
			end
		end
	end

	// Hang guard
	always @(posedge enc_clk) begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Run hung in case %s, stopped after %0d cycles", cur_name, cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		int total;
		rst       = 1'b0;
		enable    = 1'b0;
		gen_speed = GEN_RAW;
		byte_req  = 1'b0;
		lane_0_tx = '0;
		lane_1_tx = '0;
		d_sel     = '0;
		sym_ack   = 1'b0;
		cur_name  = "reset";
		data_rng  = SEED;
		load_table();
		total = 0;
		for (int r = 0; r < tbl_name.size(); r++) begin
			total += tbl_blocks[r] * block_pairs(tbl_speed[r]) + tbl_tail[r];
		end
		cycle_limit = total * 12 + 200;
		repeat (2) @(negedge enc_clk);
		checks++;
		assert (!byte_ack && !sym_req) else begin
			$display("byte_ack or sym_req was high during reset");
			errors++;
		end
		rst = 1'b1;
		@(negedge enc_clk);
		for (int r = 0; r < tbl_name.size(); r++) begin
			run_row(r);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
